// ==== aquila_fabric.f ====
+incdir+hw
hw/aquila_fabric_pkg.sv
hw/data_router.sv
hw/tcm_dp.sv
hw/clint.sv
hw/aquila_fabric_top.sv
tb/tb_aquila_fabric.sv

// ==== Bender.yml ====
package:
  name: aquila_fabric

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/aquila_fabric_pkg.sv
      - hw/data_router.sv
      - hw/tcm_dp.sv
      - hw/clint.sv
      - hw/aquila_fabric_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_aquila_fabric.sv

// ==== tb/tb_aquila_fabric.sv ====
`default_nettype none

`include "aquila_fabric_settings.svh"

module tb_aquila_fabric;

    localparam int CLK_PERIOD = 100;
    localparam int N_WORDS    = 16;
    // Accesses and fetches issued by the stimulus, each one well under 10 cycles
    localparam int N_TXN      = 7 * N_WORDS + 11;
    // Covers reset and the bounded timer wait
    localparam int MARGIN     = 400;
    localparam int TCM_IW     = $clog2(`AQ_TCM_WORDS);
    localparam aquila_fabric_pkg::word_t DEV_KEY = 32'h5a5a_c3c3;

    logic                          clk_i;
    logic                          rst_n_i;
    logic                          code_req_i;
    aquila_fabric_pkg::addr_t      code_addr_i;
    logic                          code_ready_o;
    aquila_fabric_pkg::word_t      code_o;
    logic                          data_strobe_i;
    aquila_fabric_pkg::data_req_t  data_req_i;
    logic                          data_ready_o;
    aquila_fabric_pkg::word_t      data_o;
    logic                          dev_strobe_o;
    aquila_fabric_pkg::data_req_t  dev_req_o;
    logic                          dev_ready_i;
    aquila_fabric_pkg::word_t      dev_data_i;
    logic                          tmr_irq_o;
    logic                          sft_irq_o;

    int                            err_count;
    int                            check_count;
    int                            issue_count;
    int                            resp_count;
    int                            fetch_issue;
    int                            fetch_resp;
    int unsigned                   dev_delay;
    logic                          msip_shadow;
    aquila_fabric_pkg::word_t      last_rdata;
    aquila_fabric_pkg::word_t      shadow [`AQ_TCM_WORDS];
    // Outstanding data and fetch requests, oldest first
    string                         exp_name_q [$];
    aquila_fabric_pkg::word_t      exp_data_q [$];
    bit                            exp_check_q [$];
    string                         fetch_name_q [$];
    aquila_fabric_pkg::word_t      fetch_data_q [$];

    aquila_fabric_top aquila_fabric_top_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .code_req_i    (code_req_i),
        .code_addr_i   (code_addr_i),
        .code_ready_o  (code_ready_o),
        .code_o        (code_o),
        .data_strobe_i (data_strobe_i),
        .data_req_i    (data_req_i),
        .data_ready_o  (data_ready_o),
        .data_o        (data_o),
        .dev_strobe_o  (dev_strobe_o),
        .dev_req_o     (dev_req_o),
        .dev_ready_i   (dev_ready_i),
        .dev_data_i    (dev_data_i),
        .tmr_irq_o     (tmr_irq_o),
        .sft_irq_o     (sft_irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic aquila_fabric_pkg::word_t apply_byte_enables(
        input aquila_fabric_pkg::word_t   old_w,
        input aquila_fabric_pkg::word_t   new_w,
        input aquila_fabric_pkg::byte_en_t be
    );
        aquila_fabric_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // Expected read data from the memory map
    function automatic aquila_fabric_pkg::word_t ref_read(
        input aquila_fabric_pkg::data_req_t req
    );
        logic [3:0] seg;
        seg = req.addr[`AQ_XLEN-1 -: 4];
        if (seg == `AQ_SEG_TCM) return shadow[req.addr[TCM_IW+1:2]];
        if (seg == `AQ_SEG_DEV) return req.addr ^ DEV_KEY;
        // msip is the only CLINT word known ahead of time
        if (seg == `AQ_SEG_SYS && req.addr[19:16] == `AQ_CLINT_SUB) return {31'd0, msip_shadow};
        return '0;
    endfunction

    // ------------------------------
    // Drivers
    // ------------------------------

    task automatic data_access(
        input string                     name,
        input aquila_fabric_pkg::addr_t  addr,
        input aquila_fabric_pkg::word_t  wdata,
        input aquila_fabric_pkg::byte_en_t be,
        input logic                      we,
        input bit                        check
    );
        aquila_fabric_pkg::data_req_t req;
        req = '{addr: addr, wdata: wdata, be: be, we: we};
        @(negedge clk_i);
        exp_name_q.push_back(name);
        exp_data_q.push_back(ref_read(req));
        exp_check_q.push_back(check && !we);
        // Shadow state follows the write
        if (we && addr[31:28] == `AQ_SEG_TCM) begin
            shadow[addr[TCM_IW+1:2]] = apply_byte_enables(shadow[addr[TCM_IW+1:2]], wdata, be);
        end
        // msip is bit 0 of CLINT word 0, in byte lane 0
        if (we && addr[31:28] == `AQ_SEG_SYS && addr[19:16] == `AQ_CLINT_SUB
                && addr[4:2] == 0 && be[0]) begin
            msip_shadow = wdata[0];
        end
        dev_delay     = $urandom_range(4, 1);
        data_req_i    = req;
        data_strobe_i = 1'b1;
        issue_count++;
        @(negedge clk_i);
        data_strobe_i = 1'b0;
        // Request held until the response is seen
        wait (resp_count == issue_count);
    endtask

    task automatic fetch(input string name, input int unsigned word_idx);
        @(negedge clk_i);
        fetch_name_q.push_back(name);
        fetch_data_q.push_back(shadow[word_idx]);
        code_addr_i = word_idx << 2;
        code_req_i  = 1'b1;
        fetch_issue++;
        @(negedge clk_i);
        code_req_i = 1'b0;
        wait (fetch_resp == fetch_issue);
    endtask

    // Device answers after 1 to 4 cycles with the address XOR a key
    initial begin : device_model
        int unsigned wait_cycles;
        dev_ready_i = 1'b0;
        dev_data_i  = '0;
        forever begin
            @(posedge clk_i);
            if (dev_strobe_o) begin
                wait_cycles = dev_delay;
                assert (dev_req_o == data_req_i) else begin
                    err_count++;
                    $display("[ERROR] device request: expected %h, actual %h",
                             data_req_i, dev_req_o);
                end
                repeat (wait_cycles - 1) @(posedge clk_i);
                @(negedge clk_i);
                dev_ready_i = 1'b1;
                dev_data_i  = dev_req_o.addr ^ DEV_KEY;
                @(negedge clk_i);
                dev_ready_i = 1'b0;
            end
        end
    end

    // ------------------------------
    // Response checker
    // ------------------------------

    // Sampled at the rising edge, before the DUT flops move
    always @(posedge clk_i) begin : compare_responses
        string                    name;
        aquila_fabric_pkg::word_t exp;
        bit                       chk;
        if (rst_n_i) begin
            assert (!dev_ready_i || data_ready_o) else begin
                err_count++;
                $display("Device ready did not reach the data port in the same cycle");
            end
            assert (!(data_ready_o && exp_data_q.size() == 0)) else begin
                err_count++;
                $display("Data ready pulse arrived with no request outstanding");
            end
            if (data_ready_o && exp_data_q.size() != 0) begin
                name = exp_name_q.pop_front();
                exp  = exp_data_q.pop_front();
                chk  = exp_check_q.pop_front();
                if (chk) begin
                    check_count++;
                    assert (data_o === exp) else begin
                        err_count++;
                        $display("[ERROR] %s: expected %h, actual %h", name, exp, data_o);
                    end
                end
                last_rdata = data_o;
                resp_count++;
            end
            assert (!(code_ready_o && fetch_data_q.size() == 0)) else begin
                err_count++;
                $display("Fetch ready pulse arrived with no fetch outstanding");
            end
            if (code_ready_o && fetch_data_q.size() != 0) begin
                name = fetch_name_q.pop_front();
                exp  = fetch_data_q.pop_front();
                check_count++;
                assert (code_o === exp) else begin
                    err_count++;
                    $display("[ERROR] %s: expected %h, actual %h", name, exp, code_o);
                end
                fetch_resp++;
            end
        end
    end

    // Run limit from the transaction count
    initial begin : watchdog
        #((N_TXN * 10 + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired before all transactions completed");
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin : stimulus
        int unsigned              idx_list [N_WORDS];
        int unsigned              k;
        aquila_fabric_pkg::word_t t1;
        aquila_fabric_pkg::word_t t2;
        int                       w;
        rst_n_i       = 1'b0;
        code_req_i    = 1'b0;
        code_addr_i   = '0;
        data_strobe_i = 1'b0;
        data_req_i    = '0;
        err_count     = 0;
        check_count   = 0;
        issue_count   = 0;
        resp_count    = 0;
        fetch_issue   = 0;
        fetch_resp    = 0;
        dev_delay     = 1;
        msip_shadow   = 1'b0;
        void'($urandom(32'h3c07f11c));
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        assert (!tmr_irq_o && !sft_irq_o) else begin
            err_count++;
            $display("[ERROR] irq after reset: expected 00, actual %b%b", tmr_irq_o, sft_irq_o);
        end
        // Full words first, then random lane merges, then reads
        for (int i = 0; i < N_WORDS; i++) begin
            idx_list[i] = (i * 67 + 3) % `AQ_TCM_WORDS;
            data_access("tcm fill", idx_list[i] << 2, $urandom, 4'hF, 1'b1, 1'b0);
        end
        for (int i = 0; i < 2 * N_WORDS; i++) begin
            k = $urandom_range(N_WORDS - 1);
            data_access("tcm lane write", idx_list[k] << 2, $urandom,
                        $urandom_range(15), 1'b1, 1'b0);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            data_access("tcm read", idx_list[i] << 2, '0, '0, 1'b0, 1'b1);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            fetch("fetch", idx_list[i]);
        end
        // Slow device on the data port while fetches keep running
        fork
            for (int i = 0; i < N_WORDS; i++) begin
                fetch("fetch beside device", idx_list[N_WORDS - 1 - i]);
            end
            for (int i = 0; i < N_WORDS; i++) begin
                data_access("device access", 32'hC000_0000 | (i << 4), $urandom, 4'hF,
                            (i % 3) == 0, 1'b1);
            end
        join
        data_access("sink seg 8", 32'h8000_0100, '0, '0, 1'b0, 1'b1);
        data_access("sink sys sub 1", 32'hF001_0000, '0, '0, 1'b0, 1'b1);
        data_access("sink sys sub a", 32'hF00A_0040, '0, '0, 1'b0, 1'b1);
        data_access("sink seg 3", 32'h3000_0008, '0, '0, 1'b0, 1'b1);
        // Software interrupt
        data_access("msip set", 32'hF000_0000, 32'd1, 4'hF, 1'b1, 1'b0);
        data_access("msip read", 32'hF000_0000, '0, '0, 1'b0, 1'b1);
        assert (sft_irq_o === 1'b1) else begin
            err_count++;
            $display("[ERROR] msip set: expected 1, actual %b", sft_irq_o);
        end
        data_access("msip clear", 32'hF000_0000, 32'd0, 4'hF, 1'b1, 1'b0);
        assert (sft_irq_o === 1'b0) else begin
            err_count++;
            $display("[ERROR] msip clear: expected 0, actual %b", sft_irq_o);
        end
        // Timer counts and fires
        data_access("mtime read", 32'hF000_0018, '0, '0, 1'b0, 1'b0);
        t1 = last_rdata;
        data_access("mtime read", 32'hF000_0018, '0, '0, 1'b0, 1'b0);
        t2 = last_rdata;
        assert (t2 > t1) else begin
            err_count++;
            $display("[ERROR] mtime increasing: expected above %h, actual %h", t1, t2);
        end
        data_access("mtimecmp high", 32'hF000_000C, 32'd0, 4'hF, 1'b1, 1'b0);
        data_access("mtimecmp low", 32'hF000_0008, t2 + 32'd40, 4'hF, 1'b1, 1'b0);
        // Compare still ahead of mtime, so the interrupt must be low here
        assert (tmr_irq_o === 1'b0) else begin
            err_count++;
            $display("[ERROR] timer before compare: expected 0, actual %b", tmr_irq_o);
        end
        w = 0;
        while (w < 200 && !tmr_irq_o) begin
            @(negedge clk_i);
            w++;
        end
        assert (tmr_irq_o) else begin
            err_count++;
            $display("Timer interrupt did not rise within 200 cycles");
        end
        repeat (2) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/aquila_fabric_top.sv ====
`default_nettype none

module aquila_fabric_top (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    // Instruction port
    input  wire logic                          code_req_i,
    input  wire aquila_fabric_pkg::addr_t      code_addr_i,
    output logic                               code_ready_o,
    output aquila_fabric_pkg::word_t           code_o,
    // Data port
    input  wire logic                          data_strobe_i,
    input  wire aquila_fabric_pkg::data_req_t  data_req_i,
    output logic                               data_ready_o,
    output aquila_fabric_pkg::word_t           data_o,
    // External device port
    output logic                               dev_strobe_o,
    output aquila_fabric_pkg::data_req_t       dev_req_o,
    input  wire logic                          dev_ready_i,
    input  wire aquila_fabric_pkg::word_t      dev_data_i,
    // Interrupts
    output logic                               tmr_irq_o,
    output logic                               sft_irq_o
);

    localparam int IDX_W = $bits(aquila_fabric_pkg::tcm_index_t);

    // ------------------------------
    // Internal nets
    // ------------------------------

    logic                      tcm_en;
    logic                      tcm_ready;
    aquila_fabric_pkg::word_t  tcm_data;
    logic                      clint_en;
    logic                      clint_ready;
    aquila_fabric_pkg::word_t  clint_data;

    // Data-side decode and response select
    data_router data_router_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_strobe_i (data_strobe_i),
        .data_req_i    (data_req_i),
        .data_ready_o  (data_ready_o),
        .data_o        (data_o),
        .tcm_en_o      (tcm_en),
        .tcm_ready_i   (tcm_ready),
        .tcm_data_i    (tcm_data),
        .clint_en_o    (clint_en),
        .clint_ready_i (clint_ready),
        .clint_data_i  (clint_data),
        .dev_strobe_o  (dev_strobe_o),
        .dev_req_o     (dev_req_o),
        .dev_ready_i   (dev_ready_i),
        .dev_data_i    (dev_data_i)
    );

    // Fetches always go to the TCM, word index from the byte address
    tcm_dp tcm_dp_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .i_en_i    (code_req_i),
        .i_index_i (code_addr_i[IDX_W+1:2]),
        .i_data_o  (code_o),
        .i_ready_o (code_ready_o),
        .d_en_i    (tcm_en),
        .d_req_i   (data_req_i),
        .d_data_o  (tcm_data),
        .d_ready_o (tcm_ready)
    );

    // Timer and software interrupts
    clint clint_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (clint_en),
        .req_i     (data_req_i),
        .data_o    (clint_data),
        .ready_o   (clint_ready),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

`default_nettype wire

// ==== hw/clint.sv ====
`default_nettype none

module clint (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    // Register access from the router
    input  wire logic                          en_i,
    input  wire aquila_fabric_pkg::data_req_t  req_i,
    output aquila_fabric_pkg::word_t           data_o,
    output logic                               ready_o,
    // Interrupts to the core
    output logic                               tmr_irq_o,
    output logic                               sft_irq_o
);

    // Register word indices
    localparam aquila_fabric_pkg::clint_index_t IDX_MSIP   = 3'd0;
    localparam aquila_fabric_pkg::clint_index_t IDX_CMP_LO = 3'd2;
    localparam aquila_fabric_pkg::clint_index_t IDX_CMP_HI = 3'd3;
    localparam aquila_fabric_pkg::clint_index_t IDX_MTM_LO = 3'd6;
    localparam aquila_fabric_pkg::clint_index_t IDX_MTM_HI = 3'd7;

    aquila_fabric_pkg::clint_index_t idx;
    logic                            wr;
    logic                            msip_q;
    logic [63:0]                     mtimecmp_q;
    logic [63:0]                     mtime_q;
    aquila_fabric_pkg::word_t        rd_data;

    // Byte-lane merge of a write into a register word
    function automatic aquila_fabric_pkg::word_t merge_word(
        input aquila_fabric_pkg::word_t old_w,
        input aquila_fabric_pkg::word_t new_w,
        input aquila_fabric_pkg::byte_en_t be
    );
        aquila_fabric_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < $bits(be); b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign idx = req_i.addr[4:2];
    assign wr  = en_i && req_i.we;

    // ------------------------------
    // Registers
    // ------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= '1;
            mtime_q    <= '0;
        end else begin
            // Only bit 0 of msip exists, it lives in byte lane 0
            if (wr && idx == IDX_MSIP && req_i.be[0]) begin
                msip_q <= req_i.wdata[0];
            end
            if (wr && idx == IDX_CMP_LO) begin
                mtimecmp_q[31:0] <= merge_word(mtimecmp_q[31:0], req_i.wdata, req_i.be);
            end
            if (wr && idx == IDX_CMP_HI) begin
                mtimecmp_q[63:32] <= merge_word(mtimecmp_q[63:32], req_i.wdata, req_i.be);
            end
            // Timer loads on a write, otherwise free running
            if (wr && idx == IDX_MTM_LO) begin
                mtime_q[31:0] <= merge_word(mtime_q[31:0], req_i.wdata, req_i.be);
            end else if (wr && idx == IDX_MTM_HI) begin
                mtime_q[63:32] <= merge_word(mtime_q[63:32], req_i.wdata, req_i.be);
            end else begin
                mtime_q <= mtime_q + 64'd1;
            end
        end
    end

    // ------------------------------
    // Read path and interrupts
    // ------------------------------

    always_comb begin
        unique case (idx)
            IDX_MSIP:   rd_data = {31'd0, msip_q};
            IDX_CMP_LO: rd_data = mtimecmp_q[31:0];
            IDX_CMP_HI: rd_data = mtimecmp_q[63:32];
            IDX_MTM_LO: rd_data = mtime_q[31:0];
            IDX_MTM_HI: rd_data = mtime_q[63:32];
            default:    rd_data = '0;
        endcase
    end

    // Read data is payload only
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            data_o <= rd_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_o   <= 1'b0;
            tmr_irq_o <= 1'b0;
        end else begin
            ready_o   <= en_i;
            // Timer pending while mtime has reached the compare value
            tmr_irq_o <= (mtime_q >= mtimecmp_q);
        end
    end

    assign sft_irq_o = msip_q;

    // Compare resets to all ones, so no timer interrupt right out of reset
    a_tmr_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |=> !tmr_irq_o);

endmodule

`default_nettype wire

// ==== hw/tcm_dp.sv ====
`default_nettype none

`include "aquila_fabric_settings.svh"

module tcm_dp (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    // Instruction port, read only
    input  wire logic                          i_en_i,
    input  wire aquila_fabric_pkg::tcm_index_t i_index_i,
    output aquila_fabric_pkg::word_t           i_data_o,
    output logic                               i_ready_o,
    // Data port, read or byte-lane write
    input  wire logic                          d_en_i,
    input  wire aquila_fabric_pkg::data_req_t  d_req_i,
    output aquila_fabric_pkg::word_t           d_data_o,
    output logic                               d_ready_o
);

    localparam int IDX_W = $bits(aquila_fabric_pkg::tcm_index_t);
    localparam int LANES = $bits(aquila_fabric_pkg::byte_en_t);

    aquila_fabric_pkg::word_t    mem_q [`AQ_TCM_WORDS];
    aquila_fabric_pkg::tcm_index_t d_index;

    // Word index from the byte address
    assign d_index = d_req_i.addr[IDX_W+1:2];

    // ------------------------------
    // Storage
    // ------------------------------

    // Instruction fetch
    always_ff @(posedge clk_i) begin
        if (i_en_i) begin
            i_data_o <= mem_q[i_index_i];
        end
    end

    // Data access, write lands on the enable edge
    always_ff @(posedge clk_i) begin
        if (d_en_i) begin
            if (d_req_i.we) begin
                for (int b = 0; b < LANES; b++) begin
                    if (d_req_i.be[b]) begin
                        mem_q[d_index][8*b +: 8] <= d_req_i.wdata[8*b +: 8];
                    end
                end
            end
            // Old word returned on a write
            d_data_o <= mem_q[d_index];
        end
    end

    // ------------------------------
    // Ready pulses
    // ------------------------------

    // One cycle after each enable, ports independent
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            i_ready_o <= 1'b0;
            d_ready_o <= 1'b0;
        end else begin
            i_ready_o <= i_en_i;
            d_ready_o <= d_en_i;
        end
    end

    // No new data enable in the cycle of the ready pulse
    a_no_en_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        d_ready_o |-> !d_en_i);

endmodule

`default_nettype wire

// ==== hw/data_router.sv ====
`default_nettype none

`include "aquila_fabric_settings.svh"

module data_router (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    // Core data port
    input  wire logic                          data_strobe_i,
    input  wire aquila_fabric_pkg::data_req_t  data_req_i,
    output logic                               data_ready_o,
    output aquila_fabric_pkg::word_t           data_o,
    // TCM data port
    output logic                               tcm_en_o,
    input  wire logic                          tcm_ready_i,
    input  wire aquila_fabric_pkg::word_t      tcm_data_i,
    // CLINT
    output logic                               clint_en_o,
    input  wire logic                          clint_ready_i,
    input  wire aquila_fabric_pkg::word_t      clint_data_i,
    // External device port
    output logic                               dev_strobe_o,
    output aquila_fabric_pkg::data_req_t       dev_req_o,
    input  wire logic                          dev_ready_i,
    input  wire aquila_fabric_pkg::word_t      dev_data_i
);

    logic [3:0]                  seg;
    logic [3:0]                  sys_sub;
    aquila_fabric_pkg::target_e  sel_tgt;
    aquila_fabric_pkg::target_e  tgt_q;
    logic                        sink_ready_q;
    logic                        tgt_ready;

    // ------------------------------
    // Address decode
    // ------------------------------

    assign seg     = data_req_i.addr[`AQ_XLEN-1 -: 4];
    assign sys_sub = data_req_i.addr[19:16];

    always_comb begin
        unique case (seg)
            `AQ_SEG_TCM: sel_tgt = aquila_fabric_pkg::TGT_TCM;
            `AQ_SEG_DEV: sel_tgt = aquila_fabric_pkg::TGT_DEV;
            // CLINT at one sub-select, the rest of the system segment sinks
            `AQ_SEG_SYS: sel_tgt = (sys_sub == `AQ_CLINT_SUB) ?
                                   aquila_fabric_pkg::TGT_CLINT :
                                   aquila_fabric_pkg::TGT_SINK;
            default:     sel_tgt = aquila_fabric_pkg::TGT_SINK;
        endcase
    end

    // Strobe goes to exactly one target in the cycle it arrives
    assign tcm_en_o     = data_strobe_i && (sel_tgt == aquila_fabric_pkg::TGT_TCM);
    assign clint_en_o   = data_strobe_i && (sel_tgt == aquila_fabric_pkg::TGT_CLINT);
    assign dev_strobe_o = data_strobe_i && (sel_tgt == aquila_fabric_pkg::TGT_DEV);

    // Device only sees the request when it is addressed
    assign dev_req_o = (sel_tgt == aquila_fabric_pkg::TGT_DEV) ? data_req_i : '0;

    // ------------------------------
    // Target tracking
    // ------------------------------

    // Ready of whichever target owns the request
    always_comb begin
        unique case (tgt_q)
            aquila_fabric_pkg::TGT_TCM:   tgt_ready = tcm_ready_i;
            aquila_fabric_pkg::TGT_DEV:   tgt_ready = dev_ready_i;
            aquila_fabric_pkg::TGT_CLINT: tgt_ready = clint_ready_i;
            aquila_fabric_pkg::TGT_SINK:  tgt_ready = sink_ready_q;
            default:                      tgt_ready = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tgt_q        <= aquila_fabric_pkg::TGT_IDLE;
            sink_ready_q <= 1'b0;
        end else begin
            // Sink answers one cycle after its strobe
            sink_ready_q <= data_strobe_i && (sel_tgt == aquila_fabric_pkg::TGT_SINK);
            if (data_strobe_i) begin
                tgt_q <= sel_tgt;
            end else if (tgt_ready) begin
                tgt_q <= aquila_fabric_pkg::TGT_IDLE;
            end
        end
    end

    // Response picked by the latched target, sink reads zero
    assign data_ready_o = tgt_ready;

    always_comb begin
        unique case (tgt_q)
            aquila_fabric_pkg::TGT_TCM:   data_o = tcm_data_i;
            aquila_fabric_pkg::TGT_DEV:   data_o = dev_data_i;
            aquila_fabric_pkg::TGT_CLINT: data_o = clint_data_i;
            default:                      data_o = '0;
        endcase
    end

    // ------------------------------
    // Protocol checks
    // ------------------------------

    // Core waits for the ready pulse before a new strobe
    a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_strobe_i |-> (tgt_q == aquila_fabric_pkg::TGT_IDLE));

    // No data-side target answers without an outstanding request
    a_no_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tgt_q == aquila_fabric_pkg::TGT_IDLE) |->
            !(tcm_ready_i || clint_ready_i || dev_ready_i));

endmodule

`default_nettype wire

// ==== hw/aquila_fabric_pkg.sv ====
`default_nettype none

`include "aquila_fabric_settings.svh"

package aquila_fabric_pkg;

    // ------------------------------
    // Plain vector types
    // ------------------------------

    // Data word and byte address
    typedef logic [`AQ_XLEN-1:0] word_t;
    typedef logic [`AQ_XLEN-1:0] addr_t;

    // One enable per byte lane
    typedef logic [`AQ_XLEN/8-1:0] byte_en_t;

    // Word index into the TCM
    typedef logic [$clog2(`AQ_TCM_WORDS)-1:0] tcm_index_t;

    // CLINT register index, address bits 4..2
    typedef logic [2:0] clint_index_t;

    // ------------------------------
    // Router state
    // ------------------------------

    // Idle, or the target that owns the outstanding request
    typedef enum logic [2:0] {
        TGT_IDLE,
        TGT_TCM,
        TGT_DEV,
        TGT_CLINT,
        TGT_SINK
    } target_e;

    // Data request fields, held by the requester until ready
    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        byte_en_t be;
        logic     we;
    } data_req_t;

endpackage

`default_nettype wire

// ==== hw/aquila_fabric_settings.svh ====
`ifndef AQUILA_FABRIC_SETTINGS_SVH
`define AQUILA_FABRIC_SETTINGS_SVH

// ------------------------------
// Datapath
// ------------------------------

// Word and byte-address width
`define AQ_XLEN 32

// TCM depth in words, power of two
`define AQ_TCM_WORDS 1024

// ------------------------------
// Memory map
// ------------------------------

// Segment codes, taken from the top four address bits
`define AQ_SEG_TCM 4'h0
`define AQ_SEG_DEV 4'hC
`define AQ_SEG_SYS 4'hF

// System-device sub-select of the CLINT, address bits 19..16
`define AQ_CLINT_SUB 4'h0

`endif
